//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_sm4_engine
FILELIST   := filelist.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
PASS_MSG   := all tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the pass message shows up as a line of its own
sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- common/sm4_pkg.sv
package sm4_pkg;

    //////////////////////////////
    // widths
    typedef logic [31:0]  word_t;       // one sm4 word, also apb data
    typedef logic [127:0] block_t;      // word 0 in [127:96]
    typedef logic [7:0]   byte_t;
    typedef logic [5:0]   store_addr_t;
    typedef logic [11:0]  apb_addr_t;
    typedef logic [4:0]   round_t;

    localparam int NUM_ROUNDS  = 32;
    localparam int STORE_DEPTH = 64;    // key words low half, data words high half

    // system parameter, xored into the key before expansion
    localparam block_t FK = {32'ha3b1bac6, 32'h56aa3350, 32'h677d9197, 32'hb27022dc};

    //////////////////////////////
    // sm4 s-box
    localparam byte_t SBOX [256] = '{
        8'hd6, 8'h90, 8'he9, 8'hfe, 8'hcc, 8'he1, 8'h3d, 8'hb7, 8'h16, 8'hb6, 8'h14, 8'hc2,
        8'h28, 8'hfb, 8'h2c, 8'h05, 8'h2b, 8'h67, 8'h9a, 8'h76, 8'h2a, 8'hbe, 8'h04, 8'hc3,
        8'haa, 8'h44, 8'h13, 8'h26, 8'h49, 8'h86, 8'h06, 8'h99, 8'h9c, 8'h42, 8'h50, 8'hf4,
        8'h91, 8'hef, 8'h98, 8'h7a, 8'h33, 8'h54, 8'h0b, 8'h43, 8'hed, 8'hcf, 8'hac, 8'h62,
        8'he4, 8'hb3, 8'h1c, 8'ha9, 8'hc9, 8'h08, 8'he8, 8'h95, 8'h80, 8'hdf, 8'h94, 8'hfa,
        8'h75, 8'h8f, 8'h3f, 8'ha6, 8'h47, 8'h07, 8'ha7, 8'hfc, 8'hf3, 8'h73, 8'h17, 8'hba,
        8'h83, 8'h59, 8'h3c, 8'h19, 8'he6, 8'h85, 8'h4f, 8'ha8, 8'h68, 8'h6b, 8'h81, 8'hb2,
        8'h71, 8'h64, 8'hda, 8'h8b, 8'hf8, 8'heb, 8'h0f, 8'h4b, 8'h70, 8'h56, 8'h9d, 8'h35,
        8'h1e, 8'h24, 8'h0e, 8'h5e, 8'h63, 8'h58, 8'hd1, 8'ha2, 8'h25, 8'h22, 8'h7c, 8'h3b,
        8'h01, 8'h21, 8'h78, 8'h87, 8'hd4, 8'h00, 8'h46, 8'h57, 8'h9f, 8'hd3, 8'h27, 8'h52,
        8'h4c, 8'h36, 8'h02, 8'he7, 8'ha0, 8'hc4, 8'hc8, 8'h9e, 8'hea, 8'hbf, 8'h8a, 8'hd2,
        8'h40, 8'hc7, 8'h38, 8'hb5, 8'ha3, 8'hf7, 8'hf2, 8'hce, 8'hf9, 8'h61, 8'h15, 8'ha1,
        8'he0, 8'hae, 8'h5d, 8'ha4, 8'h9b, 8'h34, 8'h1a, 8'h55, 8'had, 8'h93, 8'h32, 8'h30,
        8'hf5, 8'h8c, 8'hb1, 8'he3, 8'h1d, 8'hf6, 8'he2, 8'h2e, 8'h82, 8'h66, 8'hca, 8'h60,
        8'hc0, 8'h29, 8'h23, 8'hab, 8'h0d, 8'h53, 8'h4e, 8'h6f, 8'hd5, 8'hdb, 8'h37, 8'h45,
        8'hde, 8'hfd, 8'h8e, 8'h2f, 8'h03, 8'hff, 8'h6a, 8'h72, 8'h6d, 8'h6c, 8'h5b, 8'h51,
        8'h8d, 8'h1b, 8'haf, 8'h92, 8'hbb, 8'hdd, 8'hbc, 8'h7f, 8'h11, 8'hd9, 8'h5c, 8'h41,
        8'h1f, 8'h10, 8'h5a, 8'hd8, 8'h0a, 8'hc1, 8'h31, 8'h88, 8'ha5, 8'hcd, 8'h7b, 8'hbd,
        8'h2d, 8'h74, 8'hd0, 8'h12, 8'hb8, 8'he5, 8'hb4, 8'hb0, 8'h89, 8'h69, 8'h97, 8'h4a,
        8'h0c, 8'h96, 8'h77, 8'h7e, 8'h65, 8'hb9, 8'hf1, 8'h09, 8'hc5, 8'h6e, 8'hc6, 8'h84,
        8'h18, 8'hf0, 8'h7d, 8'hec, 8'h3a, 8'hdc, 8'h4d, 8'h20, 8'h79, 8'hee, 8'h5f, 8'h3e,
        8'hd7, 8'hcb, 8'h39, 8'h48
    };

    //////////////////////////////
    // register map, byte offsets
    localparam apb_addr_t REG_CTRL   = 12'h000;   // bit 0 start
    localparam apb_addr_t REG_STATUS = 12'h004;   // bit 0 busy, bit 1 done
    localparam apb_addr_t REG_KEY    = 12'h010;
    localparam apb_addr_t REG_PT     = 12'h020;
    localparam apb_addr_t REG_CT     = 12'h030;
    localparam apb_addr_t REG_STORE  = 12'h100;   // 64 words

    typedef enum logic [1:0] {
        IDLE,
        KEY_STEP,
        DATA_STEP,
        FINISH
    } round_state_e;

    // master side of the bus
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        word_t     pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

endpackage

//--- filelist.f
common/sm4_pkg.sv
src/sm4_round_fn.sv
sm4_core/sm4_round_ctrl.sv
sm4_core/round_store.sv
src/apb_regs.sv
src/sm4_engine_top.sv
verif/clk_gen.sv
verif/sm4_engine_props.sv
verif/tb_sm4_engine.sv

//--- sm4_core/round_store.sv
`timescale 1ns/1ps

// round word memory
// key words at 0..31, data words at 32..63
module round_store (
    input  logic                 clk,
    input  logic                 wr_en_i,
    input  sm4_pkg::store_addr_t wr_addr_i,
    input  sm4_pkg::word_t       wr_data_i,
    input  logic                 rd_en_i,
    input  sm4_pkg::store_addr_t rd_addr_i,
    output sm4_pkg::word_t       rd_data_o
);

    sm4_pkg::word_t mem [sm4_pkg::STORE_DEPTH];
    sm4_pkg::word_t rd_data_q;

    // write port, driven by the round sequencer
    always_ff @(posedge clk)
    begin
        if (wr_en_i)
            mem[wr_addr_i] <= wr_data_i;
    end

    // registered read, data one cycle after rd_en
    always_ff @(posedge clk)
    begin
        if (rd_en_i)
            rd_data_q <= mem[rd_addr_i];   // old word on a same-cycle write
    end

    assign rd_data_o = rd_data_q;

endmodule

//--- sm4_core/sm4_round_ctrl.sv
`timescale 1ns/1ps

// sm4 round sequencer
// one key round, then one data round per index, every word goes to the store
module sm4_round_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start_i,
    input  sm4_pkg::block_t      key_i,
    input  sm4_pkg::block_t      pt_i,
    output logic                 busy_o,
    output logic                 done_o,
    output sm4_pkg::block_t      ct_o,
    output logic                 wr_en_o,
    output sm4_pkg::store_addr_t wr_addr_o,
    output sm4_pkg::word_t       wr_data_o
);

    sm4_pkg::round_state_e state_q;
    sm4_pkg::round_t       round_q;
    logic                  done_q;
    sm4_pkg::block_t       ct_q;

    sm4_pkg::block_t       k_q;       // K_r .. K_r+3, K_r on top
    sm4_pkg::block_t       x_q;       // X_r .. X_r+3
    sm4_pkg::word_t        rk_q;      // round key of the current index

    sm4_pkg::word_t        ck;
    sm4_pkg::word_t        key_t_in;
    sm4_pkg::word_t        key_t_out;
    sm4_pkg::word_t        data_t_in;
    sm4_pkg::word_t        data_t_out;
    sm4_pkg::word_t        rk_new;
    sm4_pkg::word_t        x_new;
    logic                  last_round;

    //////////////////////////////
    // round constants
    // byte j of CK_i is (4i+j)*7 mod 256, byte 0 on top
    for (genvar j = 0; j < 4; j++)
    begin : g_ck
        assign ck[31-8*j -: 8] = {1'b0, round_q, 2'(j)} * 8'd7;
    end

    assign key_t_in  = k_q[95:64] ^ k_q[63:32] ^ k_q[31:0] ^ ck;
    assign data_t_in = x_q[95:64] ^ x_q[63:32] ^ x_q[31:0] ^ rk_q;

    sm4_round_fn #(
        .KEY_MODE (1'b1)
    ) u_key_fn (
        .x_i (key_t_in),
        .y_o (key_t_out)
    );

    sm4_round_fn #(
        .KEY_MODE (1'b0)
    ) u_data_fn (
        .x_i (data_t_in),
        .y_o (data_t_out)
    );

    assign rk_new     = k_q[127:96] ^ key_t_out;
    assign x_new      = x_q[127:96] ^ data_t_out;
    assign last_round = (round_q == sm4_pkg::round_t'(sm4_pkg::NUM_ROUNDS - 1));

    //////////////////////////////
    // control
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state_q <= sm4_pkg::IDLE;
            round_q <= '0;
            done_q  <= 1'b0;
            ct_q    <= '0;
        end
        else
        begin
            done_q <= 1'b0;
            case (state_q)
                sm4_pkg::IDLE:
                begin
                    if (start_i)
                    begin
                        round_q <= '0;
                        state_q <= sm4_pkg::KEY_STEP;
                    end
                end
                sm4_pkg::KEY_STEP:
                begin
                    state_q <= sm4_pkg::DATA_STEP;
                end
                sm4_pkg::DATA_STEP:
                begin
                    if (last_round)
                        state_q <= sm4_pkg::FINISH;
                    else
                    begin
                        round_q <= round_q + 1'b1;
                        state_q <= sm4_pkg::KEY_STEP;
                    end
                end
                sm4_pkg::FINISH:
                begin
                    ct_q    <= {x_q[31:0], x_q[63:32], x_q[95:64], x_q[127:96]}; // reversed
                    done_q  <= 1'b1;
                    state_q <= sm4_pkg::IDLE;
                end
                default: state_q <= sm4_pkg::IDLE;
            endcase
        end
    end

    // key and data windows
    always_ff @(posedge clk)
    begin
        if (state_q == sm4_pkg::IDLE && start_i)
        begin
            k_q <= key_i ^ sm4_pkg::FK;
            x_q <= pt_i;
        end
        else if (state_q == sm4_pkg::KEY_STEP)
        begin
            k_q  <= {k_q[95:0], rk_new};
            rk_q <= rk_new;
        end
        else if (state_q == sm4_pkg::DATA_STEP)
            x_q <= {x_q[95:0], x_new};
    end

    //////////////////////////////
    // store write port, one word per round step
    assign wr_en_o   = (state_q == sm4_pkg::KEY_STEP) || (state_q == sm4_pkg::DATA_STEP);
    assign wr_addr_o = (state_q == sm4_pkg::KEY_STEP)
                     ? sm4_pkg::store_addr_t'(round_q)
                     : sm4_pkg::store_addr_t'(round_q)
                       + sm4_pkg::store_addr_t'(sm4_pkg::NUM_ROUNDS); // data half
    assign wr_data_o = (state_q == sm4_pkg::KEY_STEP) ? rk_new : x_new;

    assign busy_o = (state_q != sm4_pkg::IDLE);
    assign done_o = done_q;
    assign ct_o   = ct_q;

endmodule

//--- src/apb_regs.sv
`timescale 1ns/1ps

// apb3 register block of the sm4 engine
module apb_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  sm4_pkg::apb_req_t    req_i,
    output sm4_pkg::apb_rsp_t    rsp_o,
    input  logic                 busy_i,
    input  logic                 done_i,
    input  sm4_pkg::block_t      ct_i,
    output logic                 start_o,
    output sm4_pkg::block_t      key_o,
    output sm4_pkg::block_t      pt_o,
    output logic                 rd_en_o,
    output sm4_pkg::store_addr_t rd_addr_o,
    input  sm4_pkg::word_t       rd_data_i
);

    logic            access;
    logic            aligned;
    logic [1:0]      word_sel;
    logic            sel_ctrl;
    logic            sel_status;
    logic            sel_key;
    logic            sel_pt;
    logic            sel_ct;
    logic            sel_store;
    logic            err;
    logic            store_rd;
    logic            store_wait_q;
    logic            pready;
    logic            wr_ok;
    logic            start_q;
    logic            done_q;
    sm4_pkg::block_t key_q;
    sm4_pkg::block_t pt_q;
    sm4_pkg::word_t  rdata;

    // word 0 is the most significant
    function automatic sm4_pkg::word_t word_of(sm4_pkg::block_t b, logic [1:0] idx);
        return b[(3 - idx) * 32 +: 32];
    endfunction

    //////////////////////////////
    // address decode
    assign access     = req_i.psel & req_i.penable;
    assign aligned    = (req_i.paddr[1:0] == 2'b00);
    assign word_sel   = req_i.paddr[3:2];
    assign sel_ctrl   = aligned & (req_i.paddr == sm4_pkg::REG_CTRL);
    assign sel_status = aligned & (req_i.paddr == sm4_pkg::REG_STATUS);
    assign sel_key    = aligned & (req_i.paddr[11:4] == sm4_pkg::REG_KEY[11:4]);
    assign sel_pt     = aligned & (req_i.paddr[11:4] == sm4_pkg::REG_PT[11:4]);
    assign sel_ct     = aligned & (req_i.paddr[11:4] == sm4_pkg::REG_CT[11:4]);
    assign sel_store  = aligned & (req_i.paddr[11:8] == sm4_pkg::REG_STORE[11:8]);

    assign err = ~(sel_ctrl | sel_status | sel_key | sel_pt | sel_ct | sel_store)
               | (req_i.pwrite & (sel_ct | sel_store));   // read-only areas

    //////////////////////////////
    // handshake
    // store reads take one wait state for the synchronous memory
    assign store_rd = sel_store & ~req_i.pwrite;
    assign pready   = access & (~store_rd | store_wait_q);
    assign rd_en_o  = access & store_rd & ~store_wait_q;   // first access cycle
    assign rd_addr_o = req_i.paddr[7:2];
    assign wr_ok    = pready & req_i.pwrite & ~err;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            store_wait_q <= 1'b0;
        else
            store_wait_q <= rd_en_o;
    end

    // software registers and status
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            key_q   <= '0;
            pt_q    <= '0;
            start_q <= 1'b0;
            done_q  <= 1'b0;
        end
        else
        begin
            if (wr_ok & sel_key & ~busy_i)   // ignored during a run
                key_q[(3 - word_sel) * 32 +: 32] <= req_i.pwdata;
            if (wr_ok & sel_pt & ~busy_i)
                pt_q[(3 - word_sel) * 32 +: 32] <= req_i.pwdata;
            start_q <= wr_ok & sel_ctrl & req_i.pwdata[0] & ~busy_i;
            if (start_q)
                done_q <= 1'b0;
            else if (done_i)
                done_q <= 1'b1;
        end
    end

    //////////////////////////////
    // read mux
    always_comb
    begin
        rdata = '0;   // ctrl reads as zero
        if (sel_status)
            rdata = {30'b0, done_q, busy_i};
        else if (sel_key)
            rdata = word_of(key_q, word_sel);
        else if (sel_pt)
            rdata = word_of(pt_q, word_sel);
        else if (sel_ct)
            rdata = word_of(ct_i, word_sel);
        else if (sel_store)
            rdata = rd_data_i;
    end

    assign rsp_o.prdata  = rdata;
    assign rsp_o.pready  = pready;
    assign rsp_o.pslverr = pready & err;

    assign start_o = start_q;
    assign key_o   = key_q;
    assign pt_o    = pt_q;

endmodule

//--- src/sm4_engine_top.sv
`timescale 1ns/1ps

// sm4 block encryption engine behind an apb3 slave
module sm4_engine_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  sm4_pkg::apb_addr_t paddr_i,
    input  sm4_pkg::word_t     pwdata_i,
    output sm4_pkg::word_t     prdata_o,
    output logic               pready_o,
    output logic               pslverr_o
);

    sm4_pkg::apb_req_t    apb_req;
    sm4_pkg::apb_rsp_t    apb_rsp;

    logic                 start;
    logic                 busy;
    logic                 done;
    sm4_pkg::block_t      key;
    sm4_pkg::block_t      pt;
    sm4_pkg::block_t      ct;

    logic                 wr_en;
    sm4_pkg::store_addr_t wr_addr;
    sm4_pkg::word_t       wr_data;
    logic                 rd_en;
    sm4_pkg::store_addr_t rd_addr;
    sm4_pkg::word_t       rd_data;

    // bus ports to struct and back
    assign apb_req.psel    = psel_i;
    assign apb_req.penable = penable_i;
    assign apb_req.pwrite  = pwrite_i;
    assign apb_req.paddr   = paddr_i;
    assign apb_req.pwdata  = pwdata_i;

    assign prdata_o  = apb_rsp.prdata;
    assign pready_o  = apb_rsp.pready;
    assign pslverr_o = apb_rsp.pslverr;

    apb_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .req_i     (apb_req),
        .rsp_o     (apb_rsp),
        .busy_i    (busy),
        .done_i    (done),
        .ct_i      (ct),
        .start_o   (start),
        .key_o     (key),
        .pt_o      (pt),
        .rd_en_o   (rd_en),
        .rd_addr_o (rd_addr),
        .rd_data_i (rd_data)
    );

    sm4_round_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .start_i   (start),
        .key_i     (key),
        .pt_i      (pt),
        .busy_o    (busy),
        .done_o    (done),
        .ct_o      (ct),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr),
        .wr_data_o (wr_data)
    );

    round_store u_store (
        .clk       (clk),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

endmodule

//--- src/sm4_round_fn.sv
`timescale 1ns/1ps

// T and T' of sm4: byte-wise s-box, then linear transform
module sm4_round_fn #(
    parameter bit KEY_MODE = 1'b0   // 1 selects L' of the key schedule
) (
    input  sm4_pkg::word_t x_i,
    output sm4_pkg::word_t y_o
);

    sm4_pkg::word_t b;   // after the s-box layer

    function automatic sm4_pkg::word_t rotl(sm4_pkg::word_t w, int unsigned n);
        return (w << n) | (w >> (32 - n));
    endfunction

    // four s-boxes in parallel
    for (genvar i = 0; i < 4; i++)
    begin : g_sbox
        assign b[8*i +: 8] = sm4_pkg::SBOX[x_i[8*i +: 8]];
    end

    //////////////////////////////
    // linear layer
    if (KEY_MODE)
    begin : g_key_l
        assign y_o = b ^ rotl(b, 13) ^ rotl(b, 23);   // L'
    end
    else
    begin : g_data_l
        assign y_o = b
                   ^ rotl(b, 2)
                   ^ rotl(b, 10)
                   ^ rotl(b, 18)
                   ^ rotl(b, 24);   // L
    end

endmodule

//--- verif/clk_gen.sv
`timescale 1ns/1ps

// testbench clock and reset
module clk_gen (
    output logic clk_o,
    output logic rst_o
);

    initial
    begin
        clk_o = 1'b0;
        forever
            #4 clk_o = ~clk_o;   // 8 ns period
    end

    initial
    begin
        rst_o = 1'b0;
        repeat (8)
            @(posedge clk_o);
        #1 rst_o = 1'b1;
    end

endmodule

//--- verif/sm4_engine_props.sv
`timescale 1ns/1ps

// apb handshake and run flag properties, bound into apb_regs
module sm4_engine_props (
    input logic              clk,
    input logic              rst,
    input sm4_pkg::apb_req_t req_i,
    input sm4_pkg::apb_rsp_t rsp_i,
    input logic              busy_i,
    input logic              done_i,
    input logic              done_flag_i
);

    int unsigned fail_cnt = 0;   // summed into the testbench error count

    //////////////////////////////
    property p_ready_in_access;
        @(posedge clk) disable iff (!rst)
            rsp_i.pready |-> (req_i.psel && req_i.penable);
    endproperty

    property p_err_with_ready;
        @(posedge clk) disable iff (!rst)
            rsp_i.pslverr |-> rsp_i.pready;
    endproperty

    // done pulse and done flag both belong to an idle engine
    property p_done_not_busy;
        @(posedge clk) disable iff (!rst)
            !(busy_i && (done_i || done_flag_i));
    endproperty

    a_ready_in_access : assert property (p_ready_in_access)
    else
    begin
        fail_cnt++;
        $error("pready high outside an access phase");
    end

    a_err_with_ready : assert property (p_err_with_ready)
    else
    begin
        fail_cnt++;
        $error("pslverr high without pready");
    end

    a_done_not_busy : assert property (p_done_not_busy)
    else
    begin
        fail_cnt++;
        $error("done and busy high together");
    end

endmodule

bind apb_regs sm4_engine_props u_props (
    .clk         (clk),
    .rst         (rst),
    .req_i       (req_i),
    .rsp_i       (rsp_o),
    .busy_i      (busy_i),
    .done_i      (done_i),
    .done_flag_i (done_q)
);

//--- verif/tb_sm4_engine.sv
`timescale 1ns/1ps

module tb_sm4_engine;

    localparam int APB_TIMEOUT   = 8;     // cycles waiting for pready
    localparam int POLL_TIMEOUT  = 100;   // status reads per run
    localparam int RESET_TIMEOUT = 40;
    localparam int NUM_RANDOM    = 20;

    logic               clk;
    logic               rst;
    logic               psel;
    logic               penable;
    logic               pwrite;
    sm4_pkg::apb_addr_t paddr;
    sm4_pkg::word_t     pwdata;
    sm4_pkg::word_t     prdata;
    logic               pready;
    logic               pslverr;

    int unsigned        err_cnt;
    int unsigned        check_cnt;
    int unsigned        test_cnt;
    int unsigned        test_fail_cnt;
    int unsigned        test_err_base;
    int unsigned        last_waits;   // wait states of the latest transfer
    logic               last_slverr;

    sm4_pkg::word_t     exp_rk [32];
    sm4_pkg::word_t     exp_x  [36];   // X0 .. X35
    sm4_pkg::block_t    exp_ct;

    clk_gen u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    sm4_engine_top uut (
        .clk       (clk),
        .rst       (rst),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    //////////////////////////////
    // reference model
    function automatic sm4_pkg::word_t rot_left(sm4_pkg::word_t w, int unsigned n);
        return (w << n) | (w >> (32 - n));
    endfunction

    function automatic sm4_pkg::word_t tau(sm4_pkg::word_t a);
        sm4_pkg::word_t b;
        for (int i = 0; i < 4; i++)
            b[8*i +: 8] = sm4_pkg::SBOX[a[8*i +: 8]];
        return b;
    endfunction

    function automatic sm4_pkg::word_t t_data(sm4_pkg::word_t a);
        sm4_pkg::word_t b;
        b = tau(a);
        return b ^ rot_left(b, 2) ^ rot_left(b, 10) ^ rot_left(b, 18) ^ rot_left(b, 24);
    endfunction

    function automatic sm4_pkg::word_t t_key(sm4_pkg::word_t a);
        sm4_pkg::word_t b;
        b = tau(a);
        return b ^ rot_left(b, 13) ^ rot_left(b, 23);
    endfunction

    function automatic sm4_pkg::word_t ck_word(int unsigned i);
        sm4_pkg::word_t w;
        for (int j = 0; j < 4; j++)
            w[31 - 8*j -: 8] = 8'(((4 * i + j) * 7) % 256);   // byte 0 on top
        return w;
    endfunction

    task automatic model_encrypt(input sm4_pkg::block_t key, input sm4_pkg::block_t pt);
        sm4_pkg::word_t k [36];
        for (int i = 0; i < 4; i++)
        begin
            k[i]     = key[127 - 32*i -: 32] ^ sm4_pkg::FK[127 - 32*i -: 32];
            exp_x[i] = pt[127 - 32*i -: 32];
        end
        for (int i = 0; i < 32; i++)
        begin
            k[i+4]     = k[i] ^ t_key(k[i+1] ^ k[i+2] ^ k[i+3] ^ ck_word(i));
            exp_rk[i]  = k[i+4];
            exp_x[i+4] = exp_x[i] ^ t_data(exp_x[i+1] ^ exp_x[i+2] ^ exp_x[i+3] ^ exp_rk[i]);
        end
        exp_ct = {exp_x[35], exp_x[34], exp_x[33], exp_x[32]};
    endtask

    function automatic sm4_pkg::block_t random_block();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    //////////////////////////////
    // checks and bus access
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $finish;
    endtask

    task automatic check_value(input string name, input sm4_pkg::word_t got,
                               input sm4_pkg::word_t exp);
        check_cnt++;
        assert (got === exp)
        else
        begin
            $display("Error %s: got %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic apb_xfer(input logic write, input sm4_pkg::apb_addr_t addr,
                            input sm4_pkg::word_t wdata, output sm4_pkg::word_t rdata);
        int unsigned waits;
        waits = 0;
        @(posedge clk);
        #1;
        psel    = 1'b1;   // setup phase
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);   // outputs settled mid-cycle
        while (!pready && waits < APB_TIMEOUT)
        begin
            @(negedge clk);
            waits++;
        end
        if (!pready)
            abort_run($sformatf("timeout: no pready on the transfer to address %h", addr));
        rdata       = prdata;
        last_slverr = pslverr;
        last_waits  = waits;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input sm4_pkg::apb_addr_t addr, input sm4_pkg::word_t data);
        sm4_pkg::word_t unused;
        apb_xfer(1'b1, addr, data, unused);
        check_value($sformatf("pslverr at %h", addr), 32'(last_slverr), 32'h0);
    endtask

    task automatic read_reg(input sm4_pkg::apb_addr_t addr, output sm4_pkg::word_t data);
        apb_xfer(1'b0, addr, 32'h0, data);
        check_value($sformatf("pslverr at %h", addr), 32'(last_slverr), 32'h0);
    endtask

    task automatic expect_error(input logic write, input sm4_pkg::apb_addr_t addr);
        sm4_pkg::word_t unused;
        apb_xfer(write, addr, $urandom(), unused);
        check_value($sformatf("pslverr at %h", addr), 32'(last_slverr), 32'h1);
    endtask

    task automatic load_block(input sm4_pkg::apb_addr_t base, input sm4_pkg::block_t blk);
        for (int w = 0; w < 4; w++)
            write_reg(sm4_pkg::apb_addr_t'(base + 4*w), blk[127 - 32*w -: 32]);
    endtask

    task automatic wait_done();
        sm4_pkg::word_t status;
        int unsigned    polls;
        polls = 0;
        read_reg(sm4_pkg::REG_STATUS, status);
        while (!status[1] && polls < POLL_TIMEOUT)
        begin
            read_reg(sm4_pkg::REG_STATUS, status);
            polls++;
        end
        if (!status[1])
            abort_run("timeout: the done bit in STATUS never came up");
    endtask

    task automatic check_ct();
        sm4_pkg::word_t data;
        for (int w = 0; w < 4; w++)
        begin
            read_reg(sm4_pkg::apb_addr_t'(sm4_pkg::REG_CT + 4*w), data);
            check_value($sformatf("REG_CT word %0d", w), data, exp_ct[127 - 32*w -: 32]);
        end
    endtask

    task automatic run_and_check(input sm4_pkg::block_t key, input sm4_pkg::block_t pt);
        model_encrypt(key, pt);
        load_block(sm4_pkg::REG_KEY, key);
        load_block(sm4_pkg::REG_PT, pt);
        write_reg(sm4_pkg::REG_CTRL, 32'h1);
        wait_done();
        check_ct();
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == test_err_base)
            $display("%-16s ok", name);
        else
        begin
            test_fail_cnt++;
            $display("%-16s FAILED with %0d errors", name, err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    //////////////////////////////
    // tests
    task automatic test_standard_vector();
        sm4_pkg::word_t  status;
        sm4_pkg::block_t v;
        v = 128'h0123456789abcdeffedcba9876543210;
        read_reg(sm4_pkg::REG_STATUS, status);
        check_value("STATUS after reset", status, 32'h0);
        load_block(sm4_pkg::REG_KEY, v);
        load_block(sm4_pkg::REG_PT, v);
        write_reg(sm4_pkg::REG_CTRL, 32'h1);
        wait_done();
        exp_ct = 128'h681edf34d206965e86b3e94f536e4246;   // published vector
        check_ct();
    endtask

    task automatic test_store_contents();
        sm4_pkg::word_t data;
        run_and_check(random_block(), random_block());
        for (int a = 0; a < 64; a++)
        begin
            read_reg(sm4_pkg::apb_addr_t'(sm4_pkg::REG_STORE + 4*a), data);
            check_value($sformatf("REG_STORE[%0d]", a), data,
                        (a < 32) ? exp_rk[a] : exp_x[a - 28]);   // X4 at word 32
            check_value($sformatf("wait states of REG_STORE[%0d]", a), 32'(last_waits), 32'h1);
        end
    endtask

    task automatic test_status();
        sm4_pkg::word_t  status;
        sm4_pkg::block_t key;
        sm4_pkg::block_t pt;
        key = random_block();
        pt  = random_block();
        model_encrypt(key, pt);
        load_block(sm4_pkg::REG_KEY, key);
        load_block(sm4_pkg::REG_PT, pt);
        write_reg(sm4_pkg::REG_CTRL, 32'h1);
        read_reg(sm4_pkg::REG_STATUS, status);
        check_value("STATUS after start", status, 32'h1);   // old done cleared
        write_reg(sm4_pkg::REG_CTRL, 32'h1);   // ignored while busy
        wait_done();
        read_reg(sm4_pkg::REG_STATUS, status);
        check_value("STATUS after run", status, 32'h2);
        check_ct();
        write_reg(sm4_pkg::REG_CTRL, 32'h1);
        read_reg(sm4_pkg::REG_STATUS, status);
        check_value("STATUS after restart", status, 32'h1);
        wait_done();
        check_ct();
    endtask

    task automatic test_errors();
        sm4_pkg::block_t key;
        sm4_pkg::block_t pt;
        sm4_pkg::word_t  data;
        expect_error(1'b0, 12'h008);
        expect_error(1'b0, 12'h040);
        expect_error(1'b0, 12'h200);
        expect_error(1'b0, 12'h012);   // misaligned
        expect_error(1'b1, sm4_pkg::apb_addr_t'(sm4_pkg::REG_CT + 4));
        expect_error(1'b1, sm4_pkg::apb_addr_t'(sm4_pkg::REG_STORE + 12'h024));
        key = random_block();
        pt  = random_block();
        model_encrypt(key, pt);
        load_block(sm4_pkg::REG_KEY, key);
        load_block(sm4_pkg::REG_PT, pt);
        write_reg(sm4_pkg::REG_CTRL, 32'h1);
        load_block(sm4_pkg::REG_KEY, random_block());   // lands mid-run
        wait_done();
        check_ct();
        // key register still holds the key of the run
        for (int w = 0; w < 4; w++)
        begin
            read_reg(sm4_pkg::apb_addr_t'(sm4_pkg::REG_KEY + 4*w), data);
            check_value($sformatf("REG_KEY word %0d", w), data, key[127 - 32*w -: 32]);
        end
    endtask

    initial
    begin
        int unsigned cycles;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        err_cnt       = 0;
        check_cnt     = 0;
        test_cnt      = 0;
        test_fail_cnt = 0;
        test_err_base = 0;
        void'($urandom(32'h62d2));
        cycles = 0;
        while (!rst && cycles < RESET_TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!rst)
            abort_run("timeout: reset was never released");

        test_standard_vector();
        end_test("standard vector");
        for (int n = 0; n < NUM_RANDOM; n++)
            run_and_check(random_block(), random_block());
        end_test("random runs");
        test_store_contents();
        end_test("store contents");
        test_status();
        end_test("status");
        test_errors();
        end_test("errors");

        err_cnt += uut.u_regs.u_props.fail_cnt;   // bound assertion failures
        $display("tests run %0d, failing %0d, checks %0d, errors %0d",
                 test_cnt, test_fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
